/* tb.f */
+incdir+src
+incdir+tb
src/dec_pkg.sv
src/instr_fields.sv
src/operand_resolve.sv
src/dispatch_ctrl.sv
src/dec_top.sv
tb/tb_dec.sv

/* tb/dec_model.svh */
localparam int F_TYPE   = 0;
localparam int F_DEST   = 1;
localparam int F_RESULT = 2;
localparam int F_IADDR  = 3;
localparam int F_JADDR  = 4;
localparam int F_STATE  = 5;
localparam int F_JUMP   = 6;
localparam int F_OP     = 7;
localparam int F_ALT    = 8;
localparam int F_DEP1   = 9;
localparam int F_DEP2   = 10;
localparam int F_VAL1   = 11;
localparam int F_VAL2   = 12;
localparam int F_IMM    = 13;
localparam int F_ROBID  = 14;
localparam int F_MEM    = 15;

localparam logic [31:0] NO_DEP = (32'd1 << `DEC_ROB_ID_W) - 32'd1;

logic        exp_stall;
logic        exp_rob;
logic        exp_rs;
logic        exp_lsb;
logic        exp_rf;
logic [31:0] exp_field [0:15];
logic [15:0] exp_known;  // Packet field written at least once

task automatic clear_model();
    exp_stall = 1'b0;
    exp_rob   = 1'b0;
    exp_rs    = 1'b0;
    exp_lsb   = 1'b0;
    exp_rf    = 1'b0;
    exp_known = '0;
endtask

task automatic set_expect(input int idx, input logic [31:0] value);
    exp_field[idx] = value;
    exp_known[idx] = 1'b1;
endtask

task automatic resolve_source(input logic [31:0] tag, input logic [31:0] rf_val,
                              input logic found, input logic [31:0] rob_val,
                              output logic [31:0] dep, output logic [31:0] val);
    if (tag == NO_DEP) begin
        dep = NO_DEP;
        val = rf_val;
    end else if (found) begin
        dep = NO_DEP;  // Producer done, value forwarded
        val = rob_val;
    end else begin
        dep = tag;
        val = 32'd0;
    end
endtask

task automatic predict_dispatch();
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [31:0] i_imm;
    logic [31:0] dep1;
    logic [31:0] dep2;
    logic [31:0] val1;
    logic [31:0] val2;
    logic        upper;
    logic        jal;
    logic        jalr;
    logic        br;
    logic        load;
    logic        store;
    logic        opimm;
    logic        opreg;
    logic        need_rs;
    logic        accept;
    logic        full;
    opc   = if_instr[6:0];
    f3    = if_instr[14:12];
    upper = (opc == 7'b0110111) || (opc == 7'b0010111);
    jal   = (opc == 7'b1101111);
    jalr  = (opc == 7'b1100111);
    br    = (opc == 7'b1100011);
    load  = (opc == 7'b0000011);
    store = (opc == 7'b0100011);
    opimm = (opc == 7'b0010011);
    opreg = (opc == 7'b0110011);
    if (!rdy_in)
        return;  // Everything holds
    need_rs = jalr || br || opimm || opreg;
    accept  = if_valid && !need_flush_in &&
              (upper || jal || jalr || br || load || store || opimm || opreg);
    full    = rob_full || (need_rs && rs_full) || (load && lb_full) || (store && sb_full);
    exp_stall = accept && full;
    exp_rob   = accept && !full;
    exp_rs    = exp_rob && need_rs;
    exp_lsb   = exp_rob && (load || store);
    exp_rf    = exp_rob && !br && !store;
    if (!exp_rob)
        return;
    i_imm = {{20{if_instr[31]}}, if_instr[31:20]};
    if (opimm && f3[1:0] == 2'b01)
        i_imm = {27'd0, if_instr[24:20]};  // Shift amount
    resolve_source({28'd0, rf_dependency1}, rf_value1, rob_is_found_1, rob_value1, dep1, val1);
    resolve_source({28'd0, rf_dependency2}, rf_value2, rob_is_found_2, rob_value2, dep2, val2);
    set_expect(F_IADDR, if_instr_addr);
    set_expect(F_ROBID, {28'd0, rob_next_rob_id});
    set_expect(F_TYPE, jalr ? 32'd4 : br ? 32'd5 : store ? {29'd0, f3} : 32'd3);
    set_expect(F_STATE, (upper || jal) ? 32'd2 : 32'd1);
    set_expect(F_JUMP, (jal || jalr) ? 32'd1 : {31'd0, (upper || br) && if_is_jump});
    if (!br && !store)
        set_expect(F_DEST, {27'd0, if_instr[11:7]});
    if (upper)
        set_expect(F_RESULT, {if_instr[31:12], 12'h000});
    if (jal)
        set_expect(F_RESULT, if_instr_addr + 32'd4);
    if (jal || jalr || br)
        set_expect(F_JADDR, if_jump_addr);
    if (need_rs) begin
        if (jalr)
            set_expect(F_OP, 32'd0);
        else if (!br)
            set_expect(F_OP, {29'd0, f3});
        else if (f3 == 3'b100)
            set_expect(F_OP, 32'd2);  // BLT as SLT
        else if (f3 == 3'b110)
            set_expect(F_OP, 32'd3);
        else
            set_expect(F_OP, {28'd0, 1'b1, f3});
        set_expect(F_ALT, {31'd0, if_instr[30] && (opreg || (opimm && f3 == 3'b101))});
    end
    if (need_rs || load || store) begin
        set_expect(F_DEP1, dep1);
        set_expect(F_VAL1, val1);
        set_expect(F_DEP2, (jalr || load || opimm) ? NO_DEP : dep2);
        set_expect(F_VAL2, (jalr || load || opimm) ? i_imm : val2);
    end
    if (load || store)
        set_expect(F_MEM, {28'd0, store, f3});
    if (store)
        set_expect(F_IMM, {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]});
endtask

/* tb/tb_dec.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dec_config.svh"

module tb_dec;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    localparam int IDLE_CYCLES  = 4;
    localparam int NUM_CYCLES   = 4000;
    localparam int LIMIT_NS     = 2 * (RESET_CYCLES + IDLE_CYCLES + NUM_CYCLES) * CLK_PERIOD;

    logic                      clk_in = 1'b0;
    logic                      arst_n;
    logic                      rdy_in;
    logic                      if_valid;
    logic [`DEC_XLEN-1:0]      if_instr;
    logic [`DEC_XLEN-1:0]      if_instr_addr;
    logic                      if_is_jump;
    logic [`DEC_XLEN-1:0]      if_jump_addr;
    logic                      need_flush_in;
    logic [`DEC_ROB_ID_W-1:0]  rob_next_rob_id;
    logic [`DEC_ROB_ID_W-1:0]  rf_dependency1;
    logic [`DEC_ROB_ID_W-1:0]  rf_dependency2;
    logic [`DEC_XLEN-1:0]      rf_value1;
    logic [`DEC_XLEN-1:0]      rf_value2;
    logic                      rob_is_found_1;
    logic [`DEC_XLEN-1:0]      rob_value1;
    logic                      rob_is_found_2;
    logic [`DEC_XLEN-1:0]      rob_value2;
    logic                      rob_full;
    logic                      rs_full;
    logic                      lb_full;
    logic                      sb_full;
    logic                      is_stall_out;
    logic                      dec2rob_ready;
    logic                      dec2rs_ready;
    logic                      dec2lsb_ready;
    logic                      dec2rf_ready;
    logic [2:0]                rob_type_out;
    logic [`DEC_REG_IDX_W-1:0] dest_out;
    logic [`DEC_XLEN-1:0]      result_value_out;
    logic [`DEC_XLEN-1:0]      instr_addr_out;
    logic [`DEC_XLEN-1:0]      jump_addr_out;
    logic [1:0]                rob_state_out;
    logic                      is_jump_out;
    logic [3:0]                calc_op_out;
    logic                      calc_alt_out;
    logic [`DEC_ROB_ID_W-1:0]  dependency1_out;
    logic [`DEC_ROB_ID_W-1:0]  dependency2_out;
    logic [`DEC_XLEN-1:0]      value1_out;
    logic [`DEC_XLEN-1:0]      value2_out;
    logic [`DEC_XLEN-1:0]      imm_out;
    logic [`DEC_ROB_ID_W-1:0]  rob_id_out;
    logic [3:0]                mem_type_out;
    logic [`DEC_REG_IDX_W-1:0] rs1_out;
    logic [`DEC_REG_IDX_W-1:0] rs2_out;

    integer seed;
    int     errors = 0;
    int     checks = 0;
    int     cycle = 0;

    `include "dec_model.svh"

    dec_top i_dut (.*);

    always #(CLK_PERIOD / 2) clk_in = ~clk_in;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("error %s at cycle %0d: expected %h, actual %h",
                     name, cycle, expected, actual);
        end
    endtask

    task automatic build_instr(output logic [31:0] ins);
        logic [31:0] r;
        logic [2:0]  f3;
        int unsigned pick;
        r    = $random(seed);
        pick = $unsigned($random(seed)) % 11;
        ins  = r;
        f3   = r[14:12];
        case (pick)
            0: ins[6:0] = 7'b0110111;  // LUI
            1: ins[6:0] = 7'b0010111;  // AUIPC
            2: ins[6:0] = 7'b1101111;
            3: ins[6:0] = 7'b1100111;  // JALR with any funct3
            4: begin
                if (f3[2:1] == 2'b01)
                    f3[2] = 1'b1;  // No branch with funct3 01x
                ins[14:12] = f3;
                ins[6:0]   = 7'b1100011;
            end
            5: begin
                if (f3 == 3'b011)
                    f3 = 3'b010;
                else if (f3[2:1] == 2'b11)
                    f3[2:1] = 2'b10;
                ins[14:12] = f3;
                ins[6:0]   = 7'b0000011;
            end
            6: begin
                ins[14:12] = (f3[1:0] == 2'b11) ? 3'b010 : {1'b0, f3[1:0]};
                ins[6:0]   = 7'b0100011;
            end
            7: begin
                if (f3[1:0] == 2'b01)
                    ins[31:25] = {1'b0, r[30] && f3[2], 5'b0};  // SLLI, SRLI, SRAI
                ins[6:0] = 7'b0010011;
            end
            8: begin
                ins[31:25] = {1'b0, r[30], 5'b0};
                ins[6:0]   = 7'b0110011;
            end
            9: ins[1:0] = (r[1:0] == 2'b11) ? 2'b01 : r[1:0];  // Compressed quadrant
            default: ins[6:0] = r[0] ? 7'b0001111 : 7'b1110011;  // FENCE or SYSTEM
        endcase
    endtask

    task automatic drive_random();
        logic [31:0] ins;
        logic [31:0] r;
        logic [31:0] tags;
        build_instr(ins);
        r    = $random(seed);
        tags = $random(seed);
        if_instr        <= ins;
        if_valid        <= r[2:0] != 3'd0;
        rdy_in          <= r[5:3] != 3'd0;
        need_flush_in   <= r[8:6] == 3'd0;
        if_is_jump      <= r[9];
        rob_full        <= r[11:10] == 2'd0;
        rs_full         <= r[13:12] == 2'd0;
        lb_full         <= r[15:14] == 2'd0;
        sb_full         <= r[17:16] == 2'd0;
        rf_dependency1  <= r[18] ? '1 : tags[3:0];  // Half the time already committed
        rf_dependency2  <= r[19] ? '1 : tags[7:4];
        rob_is_found_1  <= r[20];
        rob_is_found_2  <= r[21];
        rob_next_rob_id <= r[25:22];
        if_instr_addr   <= $random(seed) & 32'hffff_fffc;
        if_jump_addr    <= $random(seed) & 32'hffff_fffc;
        rf_value1       <= $random(seed);
        rf_value2       <= $random(seed);
        rob_value1      <= $random(seed);
        rob_value2      <= $random(seed);
    endtask

    task automatic compare_outputs();
        check_value("is_stall_out", {31'd0, exp_stall}, {31'd0, is_stall_out});
        check_value("dec2rob_ready", {31'd0, exp_rob}, {31'd0, dec2rob_ready});
        check_value("dec2rs_ready", {31'd0, exp_rs}, {31'd0, dec2rs_ready});
        check_value("dec2lsb_ready", {31'd0, exp_lsb}, {31'd0, dec2lsb_ready});
        check_value("dec2rf_ready", {31'd0, exp_rf}, {31'd0, dec2rf_ready});
        check_value("rs1_out", {27'd0, if_instr[19:15]}, {27'd0, rs1_out});  // Same cycle
        check_value("rs2_out", {27'd0, if_instr[24:20]}, {27'd0, rs2_out});
        if (exp_known[F_TYPE]) check_value("rob_type_out", exp_field[F_TYPE], rob_type_out);
        if (exp_known[F_DEST]) check_value("dest_out", exp_field[F_DEST], dest_out);
        if (exp_known[F_RESULT]) check_value("result_value_out", exp_field[F_RESULT],
                                             result_value_out);
        if (exp_known[F_IADDR]) check_value("instr_addr_out", exp_field[F_IADDR], instr_addr_out);
        if (exp_known[F_JADDR]) check_value("jump_addr_out", exp_field[F_JADDR], jump_addr_out);
        if (exp_known[F_STATE]) check_value("rob_state_out", exp_field[F_STATE], rob_state_out);
        if (exp_known[F_JUMP]) check_value("is_jump_out", exp_field[F_JUMP], is_jump_out);
        if (exp_known[F_OP]) check_value("calc_op_out", exp_field[F_OP], calc_op_out);
        if (exp_known[F_ALT]) check_value("calc_alt_out", exp_field[F_ALT], calc_alt_out);
        if (exp_known[F_DEP1]) check_value("dependency1_out", exp_field[F_DEP1], dependency1_out);
        if (exp_known[F_DEP2]) check_value("dependency2_out", exp_field[F_DEP2], dependency2_out);
        if (exp_known[F_VAL1]) check_value("value1_out", exp_field[F_VAL1], value1_out);
        if (exp_known[F_VAL2]) check_value("value2_out", exp_field[F_VAL2], value2_out);
        if (exp_known[F_IMM]) check_value("imm_out", exp_field[F_IMM], imm_out);
        if (exp_known[F_ROBID]) check_value("rob_id_out", exp_field[F_ROBID], rob_id_out);
        if (exp_known[F_MEM]) check_value("mem_type_out", exp_field[F_MEM], mem_type_out);
    endtask

    // Predict from the inputs the DUT samples on this edge
    always @(posedge clk_in) begin
        cycle = cycle + 1;
        if (!arst_n)
            clear_model();
        else
            predict_dispatch();
    end

    always @(negedge clk_in) begin
        compare_outputs();
    end

    initial begin
        #(LIMIT_NS);
        $display("watchdog expired before the stimulus finished");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        seed            = 78689;
        arst_n          = 1'b0;
        rdy_in          = 1'b1;
        if_valid        = 1'b0;
        if_instr        = '0;
        if_instr_addr   = '0;
        if_is_jump      = 1'b0;
        if_jump_addr    = '0;
        need_flush_in   = 1'b0;
        rob_next_rob_id = '0;
        rf_dependency1  = '1;
        rf_dependency2  = '1;
        rf_value1       = '0;
        rf_value2       = '0;
        rob_is_found_1  = 1'b0;
        rob_value1      = '0;
        rob_is_found_2  = 1'b0;
        rob_value2      = '0;
        rob_full        = 1'b0;
        rs_full         = 1'b0;
        lb_full         = 1'b0;
        sb_full         = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_in);
        arst_n <= 1'b1;
        repeat (IDLE_CYCLES) @(posedge clk_in);  // Strobes stay low with no fetch
        repeat (NUM_CYCLES) begin
            drive_random();
            @(posedge clk_in);
        end
        if_valid <= 1'b0;
        rdy_in   <= 1'b1;
        repeat (2) @(posedge clk_in);
        @(negedge clk_in);
        @(posedge clk_in);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/dec_top.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dec_config.svh"

module dec_top (
    input  wire logic                      clk_in,
    input  wire logic                      arst_n,
    input  wire logic                      rdy_in,
    input  wire logic                      if_valid,
    input  wire logic [`DEC_XLEN-1:0]      if_instr,
    input  wire logic [`DEC_XLEN-1:0]      if_instr_addr,
    input  wire logic                      if_is_jump,
    input  wire logic [`DEC_XLEN-1:0]      if_jump_addr,
    input  wire logic                      need_flush_in,
    output logic                           is_stall_out,
    output logic                           dec2rob_ready,
    output logic                           dec2rs_ready,
    output logic                           dec2lsb_ready,
    output logic                           dec2rf_ready,
    output dec_pkg::rob_type_e             rob_type_out,
    output logic      [`DEC_REG_IDX_W-1:0] dest_out,
    output logic      [`DEC_XLEN-1:0]      result_value_out,
    output logic      [`DEC_XLEN-1:0]      instr_addr_out,
    output logic      [`DEC_XLEN-1:0]      jump_addr_out,
    output dec_pkg::rob_state_e            rob_state_out,
    output logic                           is_jump_out,
    output dec_pkg::calc_op_e              calc_op_out,
    output logic                           calc_alt_out,
    output logic      [`DEC_ROB_ID_W-1:0]  dependency1_out,
    output logic      [`DEC_ROB_ID_W-1:0]  dependency2_out,
    output logic      [`DEC_XLEN-1:0]      value1_out,
    output logic      [`DEC_XLEN-1:0]      value2_out,
    output logic      [`DEC_XLEN-1:0]      imm_out,
    output logic      [`DEC_ROB_ID_W-1:0]  rob_id_out,
    output dec_pkg::mem_type_e             mem_type_out,
    input  wire logic [`DEC_ROB_ID_W-1:0]  rob_next_rob_id,
    input  wire logic [`DEC_ROB_ID_W-1:0]  rf_dependency1,
    input  wire logic [`DEC_ROB_ID_W-1:0]  rf_dependency2,
    input  wire logic [`DEC_XLEN-1:0]      rf_value1,
    input  wire logic [`DEC_XLEN-1:0]      rf_value2,
    input  wire logic                      rob_is_found_1,
    input  wire logic [`DEC_XLEN-1:0]      rob_value1,
    input  wire logic                      rob_is_found_2,
    input  wire logic [`DEC_XLEN-1:0]      rob_value2,
    input  wire logic                      rob_full,
    input  wire logic                      rs_full,
    input  wire logic                      lb_full,
    input  wire logic                      sb_full,
    output logic      [`DEC_REG_IDX_W-1:0] rs1_out,
    output logic      [`DEC_REG_IDX_W-1:0] rs2_out
);

    import dec_pkg::*;

    instr_class_e               instr_class;
    logic [`DEC_REG_IDX_W-1:0]  rd;
    calc_op_e                   calc_op;
    logic                       calc_alt;
    mem_type_e                  mem_type;
    logic [`DEC_XLEN-1:0]       imm;
    logic [`DEC_ROB_ID_W-1:0]   dependency1;
    logic [`DEC_ROB_ID_W-1:0]   dependency2;
    logic [`DEC_XLEN-1:0]       value1;
    logic [`DEC_XLEN-1:0]       value2;

    instr_fields i_fields (
        .instr       (if_instr),
        .instr_class (instr_class),
        .rd          (rd),
        .rs1         (rs1_out),  // To RF and ROB lookup
        .rs2         (rs2_out),
        .calc_op     (calc_op),
        .calc_alt    (calc_alt),
        .mem_type    (mem_type),
        .imm         (imm)
    );

    operand_resolve i_resolve (
        .rf_dependency1 (rf_dependency1),
        .rf_dependency2 (rf_dependency2),
        .rob_value1     (rob_value1),
        .rob_value2     (rob_value2),
        .rf_value1      (rf_value1),
        .rf_value2      (rf_value2),
        .rob_is_found_1 (rob_is_found_1),
        .rob_is_found_2 (rob_is_found_2),
        .dependency1    (dependency1),
        .dependency2    (dependency2),
        .value1         (value1),
        .value2         (value2)
    );

    dispatch_ctrl i_ctrl (
        .clk_in           (clk_in),
        .arst_n           (arst_n),
        .rdy_in           (rdy_in),
        .if_valid         (if_valid),
        .if_instr_addr    (if_instr_addr),
        .if_is_jump       (if_is_jump),
        .if_jump_addr     (if_jump_addr),
        .need_flush_in    (need_flush_in),
        .instr_class      (instr_class),
        .rd               (rd),
        .calc_op          (calc_op),
        .calc_alt         (calc_alt),
        .mem_type         (mem_type),
        .imm              (imm),
        .dependency1      (dependency1),
        .dependency2      (dependency2),
        .value1           (value1),
        .value2           (value2),
        .rob_next_rob_id  (rob_next_rob_id),
        .rob_full         (rob_full),
        .rs_full          (rs_full),
        .lb_full          (lb_full),
        .sb_full          (sb_full),
        .is_stall_out     (is_stall_out),
        .dec2rob_ready    (dec2rob_ready),
        .dec2rs_ready     (dec2rs_ready),
        .dec2lsb_ready    (dec2lsb_ready),
        .dec2rf_ready     (dec2rf_ready),
        .rob_type_out     (rob_type_out),
        .dest_out         (dest_out),
        .result_value_out (result_value_out),
        .instr_addr_out   (instr_addr_out),
        .jump_addr_out    (jump_addr_out),
        .rob_state_out    (rob_state_out),
        .is_jump_out      (is_jump_out),
        .calc_op_out      (calc_op_out),
        .calc_alt_out     (calc_alt_out),
        .dependency1_out  (dependency1_out),
        .dependency2_out  (dependency2_out),
        .value1_out       (value1_out),
        .value2_out       (value2_out),
        .imm_out          (imm_out),
        .rob_id_out       (rob_id_out),
        .mem_type_out     (mem_type_out)
    );

endmodule

`default_nettype wire

/* src/dispatch_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dec_config.svh"

module dispatch_ctrl (
    input  wire logic                      clk_in,
    input  wire logic                      arst_n,
    input  wire logic                      rdy_in,
    input  wire logic                      if_valid,
    input  wire logic [`DEC_XLEN-1:0]      if_instr_addr,
    input  wire logic                      if_is_jump,
    input  wire logic [`DEC_XLEN-1:0]      if_jump_addr,
    input  wire logic                      need_flush_in,
    input  wire dec_pkg::instr_class_e     instr_class,
    input  wire logic [`DEC_REG_IDX_W-1:0] rd,
    input  wire dec_pkg::calc_op_e         calc_op,
    input  wire logic                      calc_alt,
    input  wire dec_pkg::mem_type_e        mem_type,
    input  wire logic [`DEC_XLEN-1:0]      imm,
    input  wire logic [`DEC_ROB_ID_W-1:0]  dependency1,
    input  wire logic [`DEC_ROB_ID_W-1:0]  dependency2,
    input  wire logic [`DEC_XLEN-1:0]      value1,
    input  wire logic [`DEC_XLEN-1:0]      value2,
    input  wire logic [`DEC_ROB_ID_W-1:0]  rob_next_rob_id,
    input  wire logic                      rob_full,
    input  wire logic                      rs_full,
    input  wire logic                      lb_full,
    input  wire logic                      sb_full,
    output logic                           is_stall_out,
    output logic                           dec2rob_ready,
    output logic                           dec2rs_ready,
    output logic                           dec2lsb_ready,
    output logic                           dec2rf_ready,
    output dec_pkg::rob_type_e             rob_type_out,
    output logic      [`DEC_REG_IDX_W-1:0] dest_out,
    output logic      [`DEC_XLEN-1:0]      result_value_out,
    output logic      [`DEC_XLEN-1:0]      instr_addr_out,
    output logic      [`DEC_XLEN-1:0]      jump_addr_out,
    output dec_pkg::rob_state_e            rob_state_out,
    output logic                           is_jump_out,
    output dec_pkg::calc_op_e              calc_op_out,
    output logic                           calc_alt_out,
    output logic      [`DEC_ROB_ID_W-1:0]  dependency1_out,
    output logic      [`DEC_ROB_ID_W-1:0]  dependency2_out,
    output logic      [`DEC_XLEN-1:0]      value1_out,
    output logic      [`DEC_XLEN-1:0]      value2_out,
    output logic      [`DEC_XLEN-1:0]      imm_out,
    output logic      [`DEC_ROB_ID_W-1:0]  rob_id_out,
    output dec_pkg::mem_type_e             mem_type_out
);

    import dec_pkg::*;

    localparam logic [`DEC_ROB_ID_W-1:0] NO_DEP = '1;

    logic      is_upper;
    logic      is_jal;
    logic      is_jalr;
    logic      is_branch;
    logic      is_load;
    logic      is_store;
    logic      needs_rs;
    logic      has_rd;
    logic      imm_src2;
    logic      take;
    logic      blocked;
    logic      go;
    rob_type_e next_rob_type;
    logic      next_is_jump;

    assign is_upper  = (instr_class == CLS_LUI) || (instr_class == CLS_AUIPC);
    assign is_jal    = (instr_class == CLS_JAL);
    assign is_jalr   = (instr_class == CLS_JALR);
    assign is_branch = (instr_class == CLS_BRANCH);
    assign is_load   = (instr_class == CLS_LOAD);
    assign is_store  = (instr_class == CLS_STORE);
    assign needs_rs  = is_jalr || is_branch || instr_class == CLS_IMM || instr_class == CLS_REG;
    assign has_rd    = !is_branch && !is_store && instr_class != CLS_ILLEGAL;
    assign imm_src2  = is_jalr || is_load || instr_class == CLS_IMM;

    assign take    = if_valid && !need_flush_in && instr_class != CLS_ILLEGAL;
    assign blocked = rob_full || (needs_rs && rs_full) || (is_load && lb_full) ||
                     (is_store && sb_full);
    assign go      = take && !blocked;

    always_comb begin
        case (instr_class)
            CLS_JALR:   next_rob_type = ROB_JALR;
            CLS_BRANCH: next_rob_type = ROB_BRANCH;
            CLS_STORE:  next_rob_type = rob_type_e'(mem_type[2:0]);  // Width from funct3
            default:    next_rob_type = ROB_REG;
        endcase
    end

    always_comb begin
        if (is_jal || is_jalr)
            next_is_jump = 1'b1;
        else if (is_upper || is_branch)
            next_is_jump = if_is_jump;  // Fetch prediction
        else
            next_is_jump = 1'b0;
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            is_stall_out  <= 1'b0;
            dec2rob_ready <= 1'b0;
            dec2rs_ready  <= 1'b0;
            dec2lsb_ready <= 1'b0;
            dec2rf_ready  <= 1'b0;
        end else if (rdy_in) begin
            is_stall_out  <= take && blocked;
            dec2rob_ready <= go;
            dec2rs_ready  <= go && needs_rs;
            dec2lsb_ready <= go && (is_load || is_store);
            dec2rf_ready  <= go && has_rd;
        end
    end

    // Packet fields hold unless an instruction issues
    always_ff @(posedge clk_in) begin
        if (rdy_in && go) begin
            instr_addr_out <= if_instr_addr;
            rob_id_out     <= rob_next_rob_id;
            rob_type_out   <= next_rob_type;
            rob_state_out  <= (is_upper || is_jal) ? ST_WRITE_RESULT : ST_EXECUTE;
            is_jump_out    <= next_is_jump;
            if (has_rd) begin
                dest_out <= rd;
            end
            if (is_upper || is_jal) begin
                result_value_out <= is_jal ? if_instr_addr + 32'd4 : imm;  // Link address
            end
            if (is_jal || is_jalr || is_branch) begin
                jump_addr_out <= if_jump_addr;
            end
            if (needs_rs) begin
                calc_op_out  <= is_jalr ? CALC_ADD_SUB : calc_op;
                calc_alt_out <= is_jalr ? 1'b0 : calc_alt;
            end
            if (needs_rs || is_load || is_store) begin
                dependency1_out <= dependency1;
                value1_out      <= value1;
                dependency2_out <= imm_src2 ? NO_DEP : dependency2;
                value2_out      <= imm_src2 ? imm : value2;
            end
            if (is_load || is_store) begin
                mem_type_out <= mem_type;
            end
            if (is_store) begin
                imm_out <= imm;  // Store offset
            end
        end
    end

endmodule

`default_nettype wire

/* src/operand_resolve.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dec_config.svh"

module operand_resolve (
    input  wire logic [`DEC_ROB_ID_W-1:0] rf_dependency1,
    input  wire logic [`DEC_ROB_ID_W-1:0] rf_dependency2,
    input  wire logic [`DEC_XLEN-1:0]     rob_value1,
    input  wire logic [`DEC_XLEN-1:0]     rob_value2,
    input  wire logic [`DEC_XLEN-1:0]     rf_value1,
    input  wire logic [`DEC_XLEN-1:0]     rf_value2,
    input  wire logic                     rob_is_found_1,
    input  wire logic                     rob_is_found_2,
    output logic      [`DEC_ROB_ID_W-1:0] dependency1,
    output logic      [`DEC_ROB_ID_W-1:0] dependency2,
    output logic      [`DEC_XLEN-1:0]     value1,
    output logic      [`DEC_XLEN-1:0]     value2
);

    localparam logic [`DEC_ROB_ID_W-1:0] NO_DEP = '1;

    logic rf_ready1;
    logic rf_ready2;

    assign rf_ready1 = &rf_dependency1;  // Value already committed
    assign rf_ready2 = &rf_dependency2;

    assign dependency1 = (rf_ready1 || rob_is_found_1) ? NO_DEP : rf_dependency1;
    assign dependency2 = (rf_ready2 || rob_is_found_2) ? NO_DEP : rf_dependency2;

    // Forwarded from ROB when the producer has finished
    assign value1 = rf_ready1 ? rf_value1 : (rob_is_found_1 ? rob_value1 : '0);
    assign value2 = rf_ready2 ? rf_value2 : (rob_is_found_2 ? rob_value2 : '0);

endmodule

`default_nettype wire

/* src/instr_fields.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dec_config.svh"

module instr_fields (
    input  wire logic [`DEC_XLEN-1:0]      instr,
    output dec_pkg::instr_class_e          instr_class,
    output logic      [`DEC_REG_IDX_W-1:0] rd,
    output logic      [`DEC_REG_IDX_W-1:0] rs1,
    output logic      [`DEC_REG_IDX_W-1:0] rs2,
    output dec_pkg::calc_op_e              calc_op,
    output logic                           calc_alt,
    output dec_pkg::mem_type_e             mem_type,
    output logic      [`DEC_XLEN-1:0]      imm
);

    import dec_pkg::*;

    opcode_e              opcode;
    logic [2:0]           funct3;
    logic                 is_shift;
    logic [`DEC_XLEN-1:0] imm_u;
    logic [`DEC_XLEN-1:0] imm_j;
    logic [`DEC_XLEN-1:0] imm_i;
    logic [`DEC_XLEN-1:0] imm_b;
    logic [`DEC_XLEN-1:0] imm_s;
    logic [`DEC_XLEN-1:0] imm_shamt;

    assign opcode = opcode_e'(instr[`DEC_OPC_MSB:`DEC_OPC_LSB]);
    assign funct3 = instr[14:12];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign imm_u     = {instr[31:12], 12'b0};
    assign imm_j     = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_i     = {{20{instr[31]}}, instr[31:20]};
    assign imm_b     = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_s     = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_shamt = {{(`DEC_XLEN-5){1'b0}}, instr[24:20]};  // Unsigned shamt
    assign is_shift  = (funct3 == 3'b001) || (funct3 == 3'b101);

    always_comb begin
        instr_class = CLS_ILLEGAL;
        if (instr[1:0] == 2'b11) begin  // Compressed forms stay illegal
            case (opcode)
                OPC_LUI:    instr_class = CLS_LUI;
                OPC_AUIPC:  instr_class = CLS_AUIPC;
                OPC_JAL:    instr_class = CLS_JAL;
                OPC_JALR:   instr_class = CLS_JALR;
                OPC_BRANCH: instr_class = CLS_BRANCH;
                OPC_LOAD:   instr_class = CLS_LOAD;
                OPC_STORE:  instr_class = CLS_STORE;
                OPC_OP_IMM: instr_class = CLS_IMM;
                OPC_OP:     instr_class = CLS_REG;
                default:    instr_class = CLS_ILLEGAL;
            endcase
        end
    end

    always_comb begin
        if (instr_class == CLS_BRANCH) begin
            case (funct3)
                3'b100:  calc_op = CALC_SLT;  // BLT reuses less-than
                3'b110:  calc_op = CALC_SLTU;
                default: calc_op = calc_op_e'({1'b1, funct3});
            endcase
        end else begin
            calc_op = calc_op_e'({1'b0, funct3});
        end
    end

    // SRAI and SUB/SRA select
    assign calc_alt = ((instr_class == CLS_REG) ||
                       (instr_class == CLS_IMM && funct3 == 3'b101)) ? instr[30] : 1'b0;

    assign mem_type = mem_type_e'({instr_class == CLS_STORE, funct3});

    always_comb begin
        case (instr_class)
            CLS_LUI, CLS_AUIPC: imm = imm_u;
            CLS_JAL:            imm = imm_j;
            CLS_JALR, CLS_LOAD: imm = imm_i;
            CLS_IMM:            imm = is_shift ? imm_shamt : imm_i;
            CLS_BRANCH:         imm = imm_b;
            CLS_STORE:          imm = imm_s;
            default:            imm = '0;
        endcase
    end

endmodule

`default_nettype wire

/* src/dec_pkg.sv */
`default_nettype none

package dec_pkg;

    typedef enum logic [4:0] {
        OPC_LOAD   = 5'b00000,
        OPC_OP_IMM = 5'b00100,
        OPC_AUIPC  = 5'b00101,
        OPC_STORE  = 5'b01000,
        OPC_OP     = 5'b01100,
        OPC_LUI    = 5'b01101,
        OPC_BRANCH = 5'b11000,
        OPC_JALR   = 5'b11001,
        OPC_JAL    = 5'b11011
    } opcode_e;

    typedef enum logic [3:0] {
        CLS_LUI,
        CLS_AUIPC,
        CLS_JAL,
        CLS_JALR,
        CLS_BRANCH,
        CLS_LOAD,
        CLS_STORE,
        CLS_IMM,
        CLS_REG,
        CLS_ILLEGAL
    } instr_class_e;

    // Store codes line up with store funct3
    typedef enum logic [2:0] {
        ROB_STORE_BYTE = 3'b000,
        ROB_STORE_HALF = 3'b001,
        ROB_STORE_WORD = 3'b010,
        ROB_REG        = 3'b011,
        ROB_JALR       = 3'b100,
        ROB_BRANCH     = 3'b101,
        ROB_EXIT       = 3'b110
    } rob_type_e;

    typedef enum logic [1:0] {
        ST_COMMIT       = 2'b00,
        ST_EXECUTE      = 2'b01,
        ST_WRITE_RESULT = 2'b10
    } rob_state_e;

    typedef enum logic [3:0] {
        CALC_ADD_SUB = 4'b0000,
        CALC_SLL     = 4'b0001,
        CALC_SLT     = 4'b0010,
        CALC_SLTU    = 4'b0011,
        CALC_XOR     = 4'b0100,
        CALC_SRL_SRA = 4'b0101,
        CALC_OR      = 4'b0110,
        CALC_AND     = 4'b0111,
        CALC_SEQ     = 4'b1000,
        CALC_SNE     = 4'b1001,
        CALC_SGE     = 4'b1101,
        CALC_SGEU    = 4'b1111
    } calc_op_e;

    typedef enum logic [3:0] {
        MEM_LB  = 4'b0000,
        MEM_LH  = 4'b0001,
        MEM_LW  = 4'b0010,
        MEM_LBU = 4'b0100,
        MEM_LHU = 4'b0101,
        MEM_SB  = 4'b1000,
        MEM_SH  = 4'b1001,
        MEM_SW  = 4'b1010
    } mem_type_e;

endpackage

`default_nettype wire

/* src/dec_config.svh */
`ifndef DEC_CONFIG_SVH
`define DEC_CONFIG_SVH

// Instruction and data word
`define DEC_XLEN 32

// Architectural register index
`define DEC_REG_IDX_W 5

// ROB entry id, all ones reads as no dependency
`define DEC_ROB_ID_W 4

// Major opcode bits inside the instruction word
`define DEC_OPC_LSB 2
`define DEC_OPC_MSB 6

`endif
